/* sprite_macros.svh */
`ifndef SPRITE_MACROS_SVH
`define SPRITE_MACROS_SVH

// horizontal timing of the 640x480 raster, in pixel clocks.
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing, in lines.
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// the fighter is SPRITE_DIM ROM pixels square, each drawn SPRITE_SCALE screen pixels wide.
`define SPRITE_DIM 8
`define SPRITE_SCALE 4

`define POSE_COUNT 6 // rows of the pose ROM are grouped per pose.

`endif

/* video_pkg.sv */
package video_pkg;

	// one screen coordinate, wide enough for the full 800x525 raster.
	typedef logic [9:0] coord_t;

	// 12-bit colour as driven onto the VGA DAC pins.
	typedef struct packed
	{
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	// each axis walks through these four phases once per line or frame.
	typedef enum logic [1:0]
	{
		ACTIVE = 2'd0, // visible pixels or lines.
		FRONT = 2'd1, // front porch.
		SYNC = 2'd2, // sync pulse, active low on the pin.
		BACK = 2'd3 // back porch.
	} sync_phase_t;

endpackage

/* fighter_pkg.sv */
package fighter_pkg;
	import video_pkg::*;

	// pose codes as the game logic sends them; 6 and 7 fall back to standing.
	typedef enum logic [2:0]
	{
		POSE_STAND = 3'd0,
		POSE_PUNCH = 3'd1,
		POSE_JUMP = 3'd2,
		POSE_CROUCH = 3'd3,
		POSE_LEFT = 3'd4,
		POSE_RIGHT = 3'd5
	} pose_t;

	typedef logic [1:0] pal_idx_t; // index 0 is transparent.

	// fighter palette. Entry 0 is never shown.
	localparam rgb_t PALETTE [4] = '{
		12'h000, // transparent slot.
		12'hDA7, // skin.
		12'h445, // dark gi.
		12'hA11 // red hair and belt.
	};

endpackage

/* video_if.sv */
`timescale 1ns/1ps

// raster position and sync from the timing generator to the sprite stage.
interface raster_if
	import video_pkg::*;
();
	coord_t draw_x;
	coord_t draw_y;
	logic blank; // high outside the 640x480 area.
	logic hsync; // active low.
	logic vsync; // active low.
	logic frame_start; // one cycle, the first cycle of vsync.

	modport src (output draw_x, draw_y, blank, hsync, vsync, frame_start);
	modport dst (input draw_x, draw_y, blank, hsync, vsync, frame_start);
endinterface

// sprite pixel with the raster signals delayed to line up with it.
interface sprite_px_if
	import video_pkg::*;
();
	coord_t draw_x;
	coord_t draw_y;
	logic blank;
	logic hsync;
	logic vsync;
	rgb_t color; // only meaningful while sprite_on is set.
	logic sprite_on;

	modport src (output draw_x, draw_y, blank, hsync, vsync, color, sprite_on);
	modport dst (input draw_x, draw_y, blank, hsync, vsync, color, sprite_on);
endinterface

/* vga_timing.sv */
`timescale 1ns/1ps
`include "sprite_macros.svh"

module vga_timing
	import video_pkg::*;
(
	input logic vga_clk,
	input logic reset,
	raster_if.src rst_out
);

	coord_t h_cnt, v_cnt;
	coord_t h_next, v_next;
	sync_phase_t h_phase, v_phase;
	sync_phase_t h_phase_next, v_phase_next;
	logic line_end;

	// advances one axis through its phases; each limit is the last count of that phase.
	function automatic sync_phase_t step_phase(input sync_phase_t phase, input coord_t cnt,
		input coord_t act_last, input coord_t frt_last, input coord_t syn_last,
		input coord_t tot_last);
		sync_phase_t nxt;
		nxt = phase;
		case (phase)
			ACTIVE:
				if (cnt == act_last)
					nxt = FRONT;
			FRONT:
				if (cnt == frt_last)
					nxt = SYNC;
			SYNC:
				if (cnt == syn_last)
					nxt = BACK;
			default:
				if (cnt == tot_last)
					nxt = ACTIVE;
		endcase
		return nxt;
	endfunction

	assign line_end = (h_cnt == coord_t'(`H_TOTAL - 1));

	always_comb
	begin
		h_next = line_end ? '0 : h_cnt + 1'b1;
		h_phase_next = step_phase(h_phase, h_cnt, coord_t'(`H_ACTIVE - 1),
			coord_t'(`H_ACTIVE + `H_FRONT - 1), coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC - 1),
			coord_t'(`H_TOTAL - 1));
		v_next = v_cnt; // the vertical axis only moves at the end of a line.
		v_phase_next = v_phase;
		if (line_end)
		begin
			v_next = (v_cnt == coord_t'(`V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
			v_phase_next = step_phase(v_phase, v_cnt, coord_t'(`V_ACTIVE - 1),
				coord_t'(`V_ACTIVE + `V_FRONT - 1), coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC - 1),
				coord_t'(`V_TOTAL - 1));
		end
	end

	always_ff @(posedge vga_clk)
	begin
		if (reset)
		begin
			h_cnt <= '0; // first cycle out of reset shows pixel (0,0).
			v_cnt <= '0;
			h_phase <= ACTIVE;
			v_phase <= ACTIVE;
			rst_out.blank <= 1'b0;
			rst_out.hsync <= 1'b1;
			rst_out.vsync <= 1'b1;
			rst_out.frame_start <= 1'b0;
		end
		else
		begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			h_phase <= h_phase_next;
			v_phase <= v_phase_next;
			rst_out.blank <= (h_phase_next != ACTIVE) || (v_phase_next != ACTIVE);
			rst_out.hsync <= (h_phase_next != SYNC);
			rst_out.vsync <= (v_phase_next != SYNC);
			rst_out.frame_start <= (v_phase != SYNC) && (v_phase_next == SYNC); // vsync falls.
		end
	end

	assign rst_out.draw_x = h_cnt;
	assign rst_out.draw_y = v_cnt;

endmodule

/* fighter_sprite.sv */
`timescale 1ns/1ps
`include "sprite_macros.svh"

module fighter_sprite
	import video_pkg::*, fighter_pkg::*;
(
	input logic vga_clk,
	input logic reset,
	input logic [2:0] pose,
	input coord_t fighter_x,
	input coord_t fighter_y,
	raster_if.dst rst_in,
	sprite_px_if.src px_out
);

	localparam int BOX_DIM = `SPRITE_DIM * `SPRITE_SCALE;
	localparam int ROM_DEPTH = `POSE_COUNT * `SPRITE_DIM;
	localparam int ROM_AW = $clog2(ROM_DEPTH);
	localparam int CELL_W = $clog2(`SPRITE_DIM);

	logic [2*`SPRITE_DIM-1:0] rom [ROM_DEPTH]; // one word per sprite row, all poses stacked.
	pose_t pose_sel, pose_q;
	coord_t pos_x_q, pos_y_q;
	coord_t off_x, off_y;
	logic in_box, in_box_q;
	logic [CELL_W-1:0] cell_row, cell_col, col_q;
	logic [ROM_AW-1:0] rom_addr;
	logic [2*`SPRITE_DIM-1:0] row_word;
	pal_idx_t idx;

	initial
	begin
		$readmemh("sprite_rom.hex", rom);
	end

	assign pose_sel = (pose < 3'(`POSE_COUNT)) ? pose_t'(pose) : POSE_STAND; // 6 and 7 stand.

	// pose and position only change at vsync so a frame is never drawn with two poses.
	always_ff @(posedge vga_clk)
	begin
		if (reset)
		begin
			pose_q <= POSE_STAND;
			pos_x_q <= '0;
			pos_y_q <= '0;
		end
		else if (rst_in.frame_start)
		begin
			pose_q <= pose_sel;
			pos_x_q <= fighter_x;
			pos_y_q <= fighter_y;
		end
	end

	assign off_x = rst_in.draw_x - pos_x_q;
	assign off_y = rst_in.draw_y - pos_y_q;
	assign in_box = (rst_in.draw_x >= pos_x_q) && (rst_in.draw_y >= pos_y_q)
		&& (off_x < coord_t'(BOX_DIM)) && (off_y < coord_t'(BOX_DIM));

	assign cell_col = CELL_W'(off_x / coord_t'(`SPRITE_SCALE)); // each ROM pixel is a 4x4 block.
	assign cell_row = CELL_W'(off_y / coord_t'(`SPRITE_SCALE));
	assign rom_addr = ROM_AW'(pose_q) * ROM_AW'(`SPRITE_DIM) + ROM_AW'(cell_row);

	always_ff @(posedge vga_clk)
	begin
		row_word <= rom[rom_addr];
		col_q <= cell_col;
		px_out.draw_x <= rst_in.draw_x;
		px_out.draw_y <= rst_in.draw_y;
	end

	always_ff @(posedge vga_clk)
	begin
		if (reset)
		begin
			in_box_q <= 1'b0;
			px_out.blank <= 1'b1;
			px_out.hsync <= 1'b1;
			px_out.vsync <= 1'b1;
		end
		else
		begin
			in_box_q <= in_box;
			px_out.blank <= rst_in.blank;
			px_out.hsync <= rst_in.hsync;
			px_out.vsync <= rst_in.vsync;
		end
	end

	// column 0 sits in the top two bits, so the hex file reads left to right.
	assign idx = row_word[2 * (`SPRITE_DIM - 1 - int'(col_q)) +: 2];
	assign px_out.sprite_on = in_box_q && (idx != '0);
	assign px_out.color = PALETTE[idx];

endmodule

/* sprite_compositor.sv */
`timescale 1ns/1ps

module sprite_compositor
	import video_pkg::*;
(
	input logic vga_clk,
	input logic reset,
	input rgb_t bg_color,
	sprite_px_if.dst px_in,
	output logic hsync,
	output logic vsync,
	output logic blank,
	output coord_t pix_x,
	output coord_t pix_y,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue
);

	rgb_t mix;

	always_comb
	begin
		mix = px_in.sprite_on ? px_in.color : bg_color; // the fighter always sits on top.
		if (px_in.blank)
			mix = '0; // the DAC must see black outside the visible area.
	end

	always_ff @(posedge vga_clk)
	begin
		pix_x <= px_in.draw_x;
		pix_y <= px_in.draw_y;
	end

	always_ff @(posedge vga_clk)
	begin
		if (reset)
		begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank <= 1'b1;
			red <= '0;
			green <= '0;
			blue <= '0;
		end
		else
		begin
			hsync <= px_in.hsync;
			vsync <= px_in.vsync;
			blank <= px_in.blank;
			red <= mix.red;
			green <= mix.green;
			blue <= mix.blue;
		end
	end

endmodule

/* fighter_render_top.sv */
`timescale 1ns/1ps

module fighter_render_top
	import video_pkg::*;
(
	input logic vga_clk,
	input logic reset,
	input logic [2:0] pose,
	input coord_t fighter_x,
	input coord_t fighter_y,
	input logic [11:0] bg_color,
	output logic hsync,
	output logic vsync,
	output logic blank,
	output coord_t pix_x,
	output coord_t pix_y,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue
);

	raster_if raster ();
	sprite_px_if sprite_px ();

	vga_timing u_timing (
		.vga_clk(vga_clk),
		.reset(reset),
		.rst_out(raster.src)
	);

	fighter_sprite u_sprite (
		.vga_clk(vga_clk),
		.reset(reset),
		.pose(pose),
		.fighter_x(fighter_x),
		.fighter_y(fighter_y),
		.rst_in(raster.dst),
		.px_out(sprite_px.src)
	);

	sprite_compositor u_compositor (
		.vga_clk(vga_clk),
		.reset(reset),
		.bg_color(rgb_t'(bg_color)), // packed as red, green, blue from the top bit down.
		.px_in(sprite_px.dst),
		.hsync(hsync),
		.vsync(vsync),
		.blank(blank),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

/* render_properties.sv */
`timescale 1ns/1ps
`include "sprite_macros.svh"

module render_properties
(
	input logic vga_clk,
	input logic reset,
	input logic hsync,
	input logic vsync,
	input logic blank,
	input logic [3:0] red,
	input logic [3:0] green,
	input logic [3:0] blue
);

	int low_run; // consecutive cycles with hsync low so far.
	int fail_count = 0;

	always_ff @(posedge vga_clk)
	begin
		if (reset || hsync)
			low_run <= 0;
		else
			low_run <= low_run + 1;
	end

	hsync_width: assert property (@(posedge vga_clk) disable iff (reset)
		$rose(hsync) |-> (low_run == `H_SYNC))
	else
	begin
		fail_count++;
		$error("hsync pulse lasted %0d cycles", low_run);
	end

	sync_in_blank: assert property (@(posedge vga_clk) disable iff (reset)
		(!hsync || !vsync) |-> blank)
	else
	begin
		fail_count++;
		$error("a sync pulse fell outside the blanking interval");
	end

	black_in_blank: assert property (@(posedge vga_clk) disable iff (reset)
		blank |-> (red == 4'd0 && green == 4'd0 && blue == 4'd0))
	else
	begin
		fail_count++;
		$error("colour was driven while blank was high");
	end

endmodule

/* render_checker.sv */
`timescale 1ns/1ps
`include "sprite_macros.svh"

module render_checker
	import video_pkg::*, fighter_pkg::*;
(
	input logic vga_clk,
	input logic reset,
	input logic [2:0] pose,
	input coord_t fighter_x,
	input coord_t fighter_y,
	input logic [11:0] bg_color,
	input logic hsync,
	input logic vsync,
	input logic blank,
	input coord_t pix_x,
	input coord_t pix_y,
	input logic [3:0] red,
	input logic [3:0] green,
	input logic [3:0] blue
);

	localparam int BOX_DIM = `SPRITE_DIM * `SPRITE_SCALE;
	localparam int HS_FIRST = `H_ACTIVE + `H_FRONT;
	localparam int VS_FIRST = `V_ACTIVE + `V_FRONT;

	logic [2*`SPRITE_DIM-1:0] rom [`POSE_COUNT * `SPRITE_DIM];
	int err_count = 0;
	int check_count = 0;
	int frame_count = 0;
	int frame_errs = 0;
	int lat_pose, lat_x, lat_y; // what the frame on screen is drawn with.
	int hist_pose [2]; // inputs seen one and two cycles back.
	int hist_x [2];
	int hist_y [2];
	int exp_x, exp_y;
	int settle;
	logic [11:0] bg_last; // the compositor registers the colour one cycle late.
	logic [11:0] exp_rgb;

	initial
	begin
		$readmemh("sprite_rom.hex", rom);
	end

	function automatic logic [11:0] expected_color(input int x, input int y);
		int dx;
		int dy;
		int p;
		logic [2*`SPRITE_DIM-1:0] word;
		logic [1:0] idx;
		dx = x - lat_x;
		dy = y - lat_y;
		if (x >= `H_ACTIVE || y >= `V_ACTIVE)
			return 12'h000;
		if (dx < 0 || dy < 0 || dx >= BOX_DIM || dy >= BOX_DIM)
			return bg_last;
		p = (lat_pose >= `POSE_COUNT) ? 0 : lat_pose; // unknown codes draw standing.
		word = rom[p * `SPRITE_DIM + dy / `SPRITE_SCALE];
		idx = word[2 * (`SPRITE_DIM - 1 - dx / `SPRITE_SCALE) +: 2];
		if (idx == 2'd0)
			return bg_last;
		return PALETTE[idx];
	endfunction

	task automatic check_val(input string name, input int exp_v, input int act_v);
		check_count++;
		if (exp_v != act_v)
		begin
			err_count++;
			frame_errs++;
			$display("[ERROR] time %0t %s: expected %0h, actual %0h", $time, name, exp_v, act_v);
		end
	endtask

	always @(negedge vga_clk)
	begin
		if (reset)
		begin
			lat_pose = 0;
			lat_x = 0;
			lat_y = 0;
			exp_x = 0;
			exp_y = 0;
			settle = 2; // the pipeline still shows reset values for two cycles.
		end
		else if (settle > 0)
		begin
			check_val("hsync", 1, int'(hsync)); // syncs idle high and the screen is blanked.
			check_val("vsync", 1, int'(vsync));
			check_val("blank", 1, int'(blank));
			check_val("red", 0, int'(red));
			check_val("green", 0, int'(green));
			check_val("blue", 0, int'(blue));
			settle--;
		end
		else
		begin
			if (exp_x == 0 && exp_y == VS_FIRST)
			begin
				$display("frame %0d: pose %0d at (%0d,%0d), %0d mismatches", frame_count + 1,
					lat_pose, lat_x, lat_y, frame_errs);
				frame_count++;
				frame_errs = 0;
				lat_pose = hist_pose[1]; // the DUT latched these when its raster reached vsync.
				lat_x = hist_x[1];
				lat_y = hist_y[1];
			end
			exp_rgb = expected_color(exp_x, exp_y);
			check_val("pix_x", exp_x, int'(pix_x));
			check_val("pix_y", exp_y, int'(pix_y));
			check_val("blank", int'(exp_x >= `H_ACTIVE || exp_y >= `V_ACTIVE), int'(blank));
			check_val("hsync", int'(exp_x < HS_FIRST || exp_x >= HS_FIRST + `H_SYNC), int'(hsync));
			check_val("vsync", int'(exp_y < VS_FIRST || exp_y >= VS_FIRST + `V_SYNC), int'(vsync));
			check_val("red", int'(exp_rgb[11:8]), int'(red));
			check_val("green", int'(exp_rgb[7:4]), int'(green));
			check_val("blue", int'(exp_rgb[3:0]), int'(blue));
			exp_x = (exp_x == `H_TOTAL - 1) ? 0 : exp_x + 1;
			if (exp_x == 0)
				exp_y = (exp_y == `V_TOTAL - 1) ? 0 : exp_y + 1;
		end
		hist_pose[1] = hist_pose[0];
		hist_x[1] = hist_x[0];
		hist_y[1] = hist_y[0];
		hist_pose[0] = int'(pose);
		hist_x[0] = int'(fighter_x);
		hist_y[0] = int'(fighter_y);
		bg_last = bg_color;
	end

endmodule

/* fighter_render_tb.sv */
`timescale 1ns/1ps
`include "sprite_macros.svh"

module fighter_render_tb
	import video_pkg::*;
();

	localparam int FRAMES = 6;
	localparam int FRAME_NS = `H_TOTAL * `V_TOTAL * 10;
	localparam int WATCHDOG_NS = (FRAMES + 2) * FRAME_NS; // the reset frame plus some margin.

	logic vga_clk = 1'b0;
	logic reset;
	logic [2:0] pose;
	coord_t fighter_x;
	coord_t fighter_y;
	logic [11:0] bg_color;
	logic hsync;
	logic vsync;
	logic blank;
	coord_t pix_x;
	coord_t pix_y;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;
	logic [2:0] shown_poses [FRAMES]; // the poses still present when vsync latches them.
	int total_errs;

	always #5 vga_clk = ~vga_clk;

	fighter_render_top dut0 (.*);
	render_checker checker0 (.*);

	bind sprite_compositor render_properties props0 (
		.vga_clk(vga_clk),
		.reset(reset),
		.hsync(hsync),
		.vsync(vsync),
		.blank(blank),
		.red(red),
		.green(green),
		.blue(blue)
	);

	// returns on the rising edge just after the DUT shows the given line.
	task automatic wait_line(input int line);
		do
			@(negedge vga_clk);
		while (int'(pix_y) != line);
		@(posedge vga_clk);
	endtask

	task automatic drive_inputs(input logic [2:0] code);
		pose <= code;
		fighter_x <= coord_t'($urandom_range(`H_ACTIVE - 1, 0));
		fighter_y <= coord_t'($urandom_range(`V_ACTIVE - 1, 0));
		bg_color <= 12'($urandom);
	endtask

	// every ROM image once, with code 6 or 7 standing in for standing.
	task automatic shuffle_poses();
		logic [2:0] tmp;
		int j;
		for (int i = 0; i < FRAMES; i++)
			shown_poses[i] = 3'(i + 1);
		shown_poses[FRAMES - 1] = 3'(6 + $urandom_range(1, 0));
		for (int i = FRAMES - 1; i > 0; i--)
		begin
			j = int'($urandom_range(i, 0));
			tmp = shown_poses[i];
			shown_poses[i] = shown_poses[j];
			shown_poses[j] = tmp;
		end
	endtask

	initial
	begin
		void'($urandom(60));
		reset = 1'b1;
		pose = 3'd0;
		fighter_x = '0;
		fighter_y = '0;
		bg_color = '0;
		shuffle_poses();
		repeat (16) @(posedge vga_clk);
		reset <= 1'b0;
		for (int f = 0; f < FRAMES; f++)
		begin
			wait_line(20);
			drive_inputs(3'($urandom_range(7, 0)));
			wait_line(int'(100 + $urandom_range(299, 0))); // overrides the first change mid-frame.
			drive_inputs(shown_poses[f]);
		end
		wait_line(20);
		wait_line(`V_ACTIVE + `V_FRONT + 1); // the last frame has been reported by now.
		total_errs = checker0.err_count + dut0.u_compositor.props0.fail_count;
		$display("%0d frames, %0d pixel checks, %0d mismatches, %0d assertion failures",
			checker0.frame_count, checker0.check_count, checker0.err_count,
			dut0.u_compositor.props0.fail_count);
		if (total_errs == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the last frame was drawn", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* files.f */
+incdir+.
video_pkg.sv
fighter_pkg.sv
video_if.sv
vga_timing.sv
fighter_sprite.sv
sprite_compositor.sv
fighter_render_top.sv
render_properties.sv
render_checker.sv
fighter_render_tb.sv

/* Makefile */
TOOL = verilator
FLAGS = --binary --timing --assert -j 0
TOP = fighter_render_tb
FILELIST = files.f
LOG = sim.log
RUN_FLAGS = +verilator+error+limit+1000
BIN = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sprite_rom.hex */
// fighter pose ROM: one 16-bit word per sprite row, 8 rows per pose, poses in code order 0 to 5.
// each word holds eight 2-bit palette indices with column 0 in the top two bits; 0 is transparent.
0FC0 // standing
0540
2AA0
6AA4
3FF0
28A0
2080
1450
0FC0 // punching
0540
2AA0
6A95
3FF0
28A0
2080
1450
4FC4 // jumping
8548
2AA0
0A80
3FF0
A028
4004
0000
0000 // crouching
0000
0FC0
0540
6AA4
3FF0
A8A8
5014
3F00 // walking left
5400
2A80
6A90
3FC0
28A0
8020
4004
00FC // walking right
0015
02A8
06A9
03FC
0A28
0802
1001
